/* src/ahb_pkg.sv */
// AHB-lite subsystem package with bus structs, command formats, encodings and address map
package ahb_pkg;

  // ----------------------------------------------------------------------
  // AHB encodings
  // ----------------------------------------------------------------------
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  // Only word transfers in this subsystem
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  localparam logic HRESP_OKAY  = 1'b0;
  localparam logic HRESP_ERROR = 1'b1;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  // SRAM region, 256 words from address zero
  localparam logic [31:0] SRAM_BASE  = 32'h0000_0000;
  localparam int          SRAM_WORDS = 256;
  // Word index width inside the SRAM
  localparam int          SRAM_AW    = $clog2(SRAM_WORDS);

  // Peripheral region, four word registers
  localparam logic [31:0] PERI_BASE     = 32'h4000_0000;
  localparam int          PERI_WORDS    = 4;
  localparam int          PERI_AW       = $clog2(PERI_WORDS);
  // Constant returned by the last peripheral register
  localparam logic [31:0] PERI_ID_VALUE = 32'h5EA5_0202;

  // ----------------------------------------------------------------------
  // Timing and buffer sizes
  // ----------------------------------------------------------------------
  localparam int SRAM_WAIT_STATES = 1;
  localparam int CMD_DEPTH        = 4;
  localparam int RSP_DEPTH        = 4;

  // ----------------------------------------------------------------------
  // Bus structs
  // ----------------------------------------------------------------------
  // Master to slave
  typedef struct packed {
    logic [31:0] haddr;
    logic [1:0]  htrans;
    logic        hwrite;
    logic [2:0]  hsize;
    logic [31:0] hwdata;
  } ahb_m2s_t;

  // Slave to master
  typedef struct packed {
    logic [31:0] hrdata;
    logic        hreadyout;
    logic        hresp;
  } ahb_s2m_t;

  // One queued command
  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } bus_cmd_t;

  // One completed transfer; rdata zero on writes and errors
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } bus_rsp_t;

endpackage

/* src/sync_fifo.sv */
// Synchronous FIFO with a type-parameterized payload, used for commands and responses
module sync_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n,
  input  logic push,
  input  T     wdata,
  input  logic pop,
  output T     rdata,
  output logic full,
  output logic empty
);

  // Pointer and occupancy widths
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  // Storage
  T              mem [DEPTH];
  logic [PW-1:0] rd_ptr_q;
  logic [PW-1:0] wr_ptr_q;
  logic [CW-1:0] count_q;

  // Qualified strobes
  logic do_push;
  logic do_pop;

  // Wrap at DEPTH, which need not be a power of two
  function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
    if (ptr == PW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Push on full and pop on empty are dropped
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // ----------------------------------------------------------------------
  // Pointers and count
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Payload array
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= wdata;
    end
  end

  // Head is visible the cycle after its push
  assign rdata = mem[rd_ptr_q];
  assign full  = (count_q == CW'(DEPTH));
  assign empty = (count_q == '0);

endmodule

/* src/ahb_cmd_master.sv */
// AHB-lite master turning buffered commands into single NONSEQ transfers and responses
module ahb_cmd_master (
  input  logic              clk,
  input  logic              rst_n,
  input  ahb_pkg::bus_cmd_t cmd,
  input  logic              cmd_empty,
  output logic              cmd_pop,
  output ahb_pkg::bus_rsp_t rsp,
  output logic              rsp_push,
  input  logic              rsp_full,
  output ahb_pkg::ahb_m2s_t m2s,
  input  ahb_pkg::ahb_s2m_t s2m
);
  import ahb_pkg::*;

  // Transfer FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_t;

  state_t   state_q;
  state_t   state_d;

  // Command held for the whole transfer
  bus_cmd_t cmd_q;
  // Response waiting for its push
  bus_rsp_t rsp_q;
  logic     rsp_push_q;

  logic     start;
  logic     done;
  logic     err;

  // ----------------------------------------------------------------------
  // Control
  // ----------------------------------------------------------------------
  // New command only with room for its response
  // A push still in flight counts as used space
  assign start = (state_q == ST_IDLE) && !cmd_empty && !rsp_full && !rsp_push_q;

  // Data phase ends on hready
  assign done = (state_q == ST_DATA) && s2m.hreadyout;
  assign err  = (s2m.hresp == HRESP_ERROR);

  assign cmd_pop = start;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start) begin
          state_d = ST_ADDR;
        end
      end
      // Single cycle address phase
      ST_ADDR: state_d = ST_DATA;
      ST_DATA: begin
        if (s2m.hreadyout) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ST_IDLE;
      rsp_push_q <= 1'b0;
      cmd_q      <= '0;
    end else begin
      state_q    <= state_d;
      // Push one cycle after the data phase ends
      rsp_push_q <= done;
      if (start) begin
        cmd_q <= cmd;
      end
    end
  end

  // Capture response at the end of the data phase
  always_ff @(posedge clk) begin
    if (done) begin
      rsp_q.err   <= err;
      // Read data only on an okay read
      rsp_q.rdata <= (!cmd_q.write && !err) ? s2m.hrdata : '0;
    end
  end

  // ----------------------------------------------------------------------
  // Bus drive
  // ----------------------------------------------------------------------
  // Address, direction and write data stay steady through the data phase
  always_comb begin
    m2s.haddr  = cmd_q.addr;
    m2s.htrans = (state_q == ST_ADDR) ? HTRANS_NONSEQ : HTRANS_IDLE;
    m2s.hwrite = cmd_q.write;
    m2s.hsize  = HSIZE_WORD;
    m2s.hwdata = cmd_q.wdata;
  end

  assign rsp      = rsp_q;
  assign rsp_push = rsp_push_q;

endmodule

/* src/ahb_lite_bus.sv */
// AHB-lite bus with address decode, response multiplexer and a default error slave
module ahb_lite_bus (
  input  logic              clk,
  input  logic              rst_n,
  input  ahb_pkg::ahb_m2s_t m2s,
  output ahb_pkg::ahb_s2m_t s2m,
  output logic              sram_hsel,
  output logic              peri_hsel,
  input  ahb_pkg::ahb_s2m_t sram_s2m,
  input  ahb_pkg::ahb_s2m_t peri_s2m
);
  import ahb_pkg::*;

  // Data phase owner
  typedef enum logic [1:0] {
    TGT_NONE,
    TGT_SRAM,
    TGT_PERI,
    TGT_DEF
  } tgt_t;

  logic     nonseq;
  logic     sram_hit;
  logic     peri_hit;
  logic     addr_phase;
  tgt_t     tgt_d;
  tgt_t     tgt_q;

  // Default slave state
  logic     def_wait_q;
  ahb_s2m_t def_s2m;

  // ----------------------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------------------
  assign nonseq   = (m2s.htrans == HTRANS_NONSEQ);
  // Byte offset bits ignored
  assign sram_hit = (m2s.haddr[31:SRAM_AW+2] == SRAM_BASE[31:SRAM_AW+2]);
  assign peri_hit = (m2s.haddr[31:PERI_AW+2] == PERI_BASE[31:PERI_AW+2]);

  assign sram_hsel = nonseq && sram_hit;
  assign peri_hsel = nonseq && peri_hit;

  // Transfer accepted when the bus is ready
  assign addr_phase = nonseq && s2m.hreadyout;

  always_comb begin
    if (!nonseq) begin
      tgt_d = TGT_NONE;
    end else if (sram_hit) begin
      tgt_d = TGT_SRAM;
    end else if (peri_hit) begin
      tgt_d = TGT_PERI;
    end else begin
      // Unmapped address
      tgt_d = TGT_DEF;
    end
  end

  // Owner moves on whenever hready is high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tgt_q      <= TGT_NONE;
      def_wait_q <= 1'b0;
    end else begin
      if (s2m.hreadyout) begin
        tgt_q <= tgt_d;
      end
      // First error cycle follows an unmapped address phase
      def_wait_q <= addr_phase && (tgt_d == TGT_DEF);
    end
  end

  // ----------------------------------------------------------------------
  // Default slave
  // ----------------------------------------------------------------------
  // Two cycle ERROR, hready low then high
  always_comb begin
    def_s2m.hrdata    = '0;
    def_s2m.hreadyout = !def_wait_q;
    def_s2m.hresp     = HRESP_ERROR;
  end

  // Response mux
  always_comb begin
    case (tgt_q)
      TGT_SRAM: s2m = sram_s2m;
      TGT_PERI: s2m = peri_s2m;
      TGT_DEF:  s2m = def_s2m;
      default: begin
        // No data phase in progress
        s2m.hrdata    = '0;
        s2m.hreadyout = 1'b1;
        s2m.hresp     = HRESP_OKAY;
      end
    endcase
  end

endmodule

/* src/ahb_sram_slave.sv */
// Word-addressed AHB-lite SRAM slave with a fixed number of wait states
module ahb_sram_slave (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              hsel,
  input  ahb_pkg::ahb_m2s_t m2s,
  output ahb_pkg::ahb_s2m_t s2m
);
  import ahb_pkg::*;

  // Wait counter width
  localparam int CW = (SRAM_WAIT_STATES > 0) ? $clog2(SRAM_WAIT_STATES + 1) : 1;

  logic [31:0]        mem [SRAM_WORDS];

  // Registered address phase
  logic               active_q;
  logic               write_q;
  logic [SRAM_AW-1:0] addr_q;
  logic [CW-1:0]      wait_q;

  logic               sel;
  logic               complete;

  assign sel      = hsel && (m2s.htrans == HTRANS_NONSEQ);
  // Last data phase cycle
  assign complete = active_q && (wait_q == '0);

  // ----------------------------------------------------------------------
  // Control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      write_q  <= 1'b0;
      addr_q   <= '0;
      wait_q   <= '0;
    end else if (sel) begin
      active_q <= 1'b1;
      write_q  <= m2s.hwrite;
      addr_q   <= m2s.haddr[SRAM_AW+1:2];
      wait_q   <= CW'(SRAM_WAIT_STATES);
    end else if (active_q) begin
      // Count down, then finish
      if (wait_q != '0) begin
        wait_q <= wait_q - 1'b1;
      end else begin
        active_q <= 1'b0;
      end
    end
  end

  // Array cleared on reset, written in the last data cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < SRAM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (complete && write_q) begin
      mem[addr_q] <= m2s.hwdata;
    end
  end

  // ----------------------------------------------------------------------
  // Response
  // ----------------------------------------------------------------------
  always_comb begin
    s2m.hreadyout = !(active_q && (wait_q != '0));
    s2m.hresp     = HRESP_OKAY;
    s2m.hrdata    = (complete && !write_q) ? mem[addr_q] : '0;
  end

endmodule

/* src/ahb_periph_slave.sv */
// AHB-lite peripheral slave with three read-write registers and a read-only ID
module ahb_periph_slave (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              hsel,
  input  ahb_pkg::ahb_m2s_t m2s,
  output ahb_pkg::ahb_s2m_t s2m
);
  import ahb_pkg::*;

  // Last register holds the ID
  localparam logic [PERI_AW-1:0] ID_IDX = PERI_AW'(PERI_WORDS - 1);

  logic [31:0]        regs [PERI_WORDS-1];

  // Registered address phase
  logic               active_q;
  logic               write_q;
  logic [PERI_AW-1:0] idx_q;

  logic               sel;

  assign sel = hsel && (m2s.htrans == HTRANS_NONSEQ);

  // Data phase is one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      write_q  <= 1'b0;
      idx_q    <= '0;
    end else begin
      active_q <= sel;
      if (sel) begin
        write_q <= m2s.hwrite;
        idx_q   <= m2s.haddr[PERI_AW+1:2];
      end
    end
  end

  // Writes to the ID slot are dropped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PERI_WORDS - 1; i++) begin
        regs[i] <= '0;
      end
    end else if (active_q && write_q && (idx_q != ID_IDX)) begin
      regs[idx_q] <= m2s.hwdata;
    end
  end

  // Never stalls
  always_comb begin
    s2m.hreadyout = 1'b1;
    s2m.hresp     = HRESP_OKAY;
    if (!active_q || write_q) begin
      s2m.hrdata = '0;
    end else if (idx_q == ID_IDX) begin
      s2m.hrdata = PERI_ID_VALUE;
    end else begin
      s2m.hrdata = regs[idx_q];
    end
  end

endmodule

/* src/ahb_subsys_top.sv */
// AHB-lite memory subsystem top joining the buffers, master, bus and slaves
module ahb_subsys_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cmd_push,
  input  ahb_pkg::bus_cmd_t cmd,
  output logic              cmd_full,
  input  logic              rsp_pop,
  output ahb_pkg::bus_rsp_t rsp,
  output logic              rsp_empty
);
  import ahb_pkg::*;

  // ----------------------------------------------------------------------
  // Internal wiring
  // ----------------------------------------------------------------------
  // Command buffer to master
  bus_cmd_t cmd_head;
  logic     cmd_empty;
  logic     cmd_pop;

  // Master to response buffer
  bus_rsp_t rsp_in;
  logic     rsp_push;
  logic     rsp_full;

  // Shared master drive and muxed response
  ahb_m2s_t m2s;
  ahb_s2m_t s2m;

  // Slave selects and responses
  logic     sram_hsel;
  logic     peri_hsel;
  ahb_s2m_t sram_s2m;
  ahb_s2m_t peri_s2m;

  sync_fifo #(
    .T     (bus_cmd_t),
    .DEPTH (CMD_DEPTH)
  ) u_cmd_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (cmd_push),
    .wdata (cmd),
    .pop   (cmd_pop),
    .rdata (cmd_head),
    .full  (cmd_full),
    .empty (cmd_empty)
  );

  ahb_cmd_master u_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd_head),
    .cmd_empty (cmd_empty),
    .cmd_pop   (cmd_pop),
    .rsp       (rsp_in),
    .rsp_push  (rsp_push),
    .rsp_full  (rsp_full),
    .m2s       (m2s),
    .s2m       (s2m)
  );

  ahb_lite_bus u_bus (
    .clk       (clk),
    .rst_n     (rst_n),
    .m2s       (m2s),
    .s2m       (s2m),
    .sram_hsel (sram_hsel),
    .peri_hsel (peri_hsel),
    .sram_s2m  (sram_s2m),
    .peri_s2m  (peri_s2m)
  );

  ahb_sram_slave u_sram (
    .clk   (clk),
    .rst_n (rst_n),
    .hsel  (sram_hsel),
    .m2s   (m2s),
    .s2m   (sram_s2m)
  );

  ahb_periph_slave u_periph (
    .clk   (clk),
    .rst_n (rst_n),
    .hsel  (peri_hsel),
    .m2s   (m2s),
    .s2m   (peri_s2m)
  );

  sync_fifo #(
    .T     (bus_rsp_t),
    .DEPTH (RSP_DEPTH)
  ) u_rsp_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (rsp_push),
    .wdata (rsp_in),
    .pop   (rsp_pop),
    .rdata (rsp),
    .full  (rsp_full),
    .empty (rsp_empty)
  );

endmodule

/* tb/ahb_subsys_props.sv */
// Bus protocol and buffer usage assertions bound into the subsystem top
module ahb_subsys_props (
  input logic              clk,
  input logic              rst_n,
  input logic              cmd_push,
  input logic              cmd_full,
  input logic              rsp_push,
  input logic              rsp_full,
  input ahb_pkg::ahb_m2s_t m2s,
  input ahb_pkg::ahb_s2m_t s2m
);
  timeunit 1ns;
  timeprecision 100ps;
  import ahb_pkg::*;

  // Data phase follows an accepted NONSEQ
  logic in_data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_data_q <= 1'b0;
    end else if (s2m.hreadyout) begin
      in_data_q <= (m2s.htrans == HTRANS_NONSEQ);
    end
  end

  // Master holds its signals through wait states
  assert property (@(posedge clk) disable iff (!rst_n)
    (in_data_q && !s2m.hreadyout) |=>
      ($stable(m2s.haddr) && $stable(m2s.hwrite) && $stable(m2s.hwdata)))
    else $error("address, direction or write data changed during a wait state");

  assert property (@(posedge clk) disable iff (!rst_n) cmd_push |-> !cmd_full)
    else $error("command pushed while the command buffer was full");

  // Two cycle ERROR response
  assert property (@(posedge clk) disable iff (!rst_n) $rose(s2m.hresp) |-> !s2m.hreadyout)
    else $error("first ERROR cycle did not hold hready low");

  assert property (@(posedge clk) disable iff (!rst_n) rsp_push |-> !rsp_full)
    else $error("response pushed while the response buffer was full");

endmodule

bind ahb_subsys_top ahb_subsys_props u_props (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_push (cmd_push),
  .cmd_full (cmd_full),
  .rsp_push (rsp_push),
  .rsp_full (rsp_full),
  .m2s      (m2s),
  .s2m      (s2m)
);

/* tb/tb_ahb_subsys.sv */
// Testbench for the AHB-lite memory subsystem, driven and checked from a vector file
module tb_ahb_subsys;
  timeunit 1ns;
  timeprecision 100ps;
  import ahb_pkg::*;

  localparam int    MAX_VEC   = 64;
  localparam int    RAW_WORDS = MAX_VEC * 5;
  localparam int    TIMEOUT   = 200;
  localparam string VEC_FILE  = "tb/ahb_subsys_testdata.txt";

  logic     clk;
  logic     rst_n;
  logic     cmd_push;
  bus_cmd_t cmd;
  logic     cmd_full;
  logic     rsp_pop;
  bus_rsp_t rsp;
  logic     rsp_empty;

  // Raw file words, five per line
  logic [31:0] raw [RAW_WORDS];

  // Decoded vectors, markers removed
  logic        v_write [MAX_VEC];
  logic [31:0] v_addr  [MAX_VEC];
  logic [31:0] v_wdata [MAX_VEC];
  logic [31:0] v_rdata [MAX_VEC];
  logic        v_err   [MAX_VEC];
  int          v_phase [MAX_VEC];
  int          num_vec;
  int          stall_start;
  int          checked;
  logic [15:0] lfsr;

  ahb_subsys_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_push  (cmd_push),
    .cmd       (cmd),
    .cmd_full  (cmd_full),
    .rsp_pop   (rsp_pop),
    .rsp       (rsp),
    .rsp_empty (rsp_empty)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // Op 0 read, 1 write, 2 phase marker, 3 end of data
  task automatic load_vectors();
    int          pos;
    int          phase;
    logic [31:0] op;
    pos = 0;
    phase = 0;
    num_vec = 0;
    stall_start = -1;
    op = raw[0];
    while (op !== 32'h3) begin
      if ($isunknown(op) || pos + 5 > RAW_WORDS || op > 32'h3) begin
        report_fail("test data file is malformed or has no end marker");
      end else if (op == 32'h2) begin
        phase = int'(raw[pos+1]);
        if (phase == 1) begin
          stall_start = num_vec;
        end
      end else begin
        v_write[num_vec] = op[0];
        v_addr[num_vec]  = raw[pos+1];
        v_wdata[num_vec] = raw[pos+2];
        v_rdata[num_vec] = raw[pos+3];
        v_err[num_vec]   = raw[pos+4][0];
        v_phase[num_vec] = phase;
        num_vec++;
      end
      pos += 5;
      op = raw[pos];
    end
    if (stall_start < 0) begin
      report_fail("test data file has no stall phase");
    end
  endtask

  // All drives land 1 ns after a rising edge
  task automatic push_vector(input int k);
    cmd.write = v_write[k];
    cmd.addr  = v_addr[k];
    cmd.wdata = v_wdata[k];
    cmd_push  = 1'b1;
    @(posedge clk);
    #1;
    cmd_push  = 1'b0;
  endtask

  task automatic wait_not_full();
    int cycles;
    cycles = 0;
    while (cmd_full) begin
      if (cycles == TIMEOUT) begin
        report_fail("timeout waiting for room in the command buffer");
      end else begin
        @(posedge clk);
        #1;
        cycles++;
      end
    end
  endtask

  // Full for TIMEOUT cycles in a row means the master has stopped
  task automatic wait_room_or_stall(output logic stalled);
    int cycles;
    cycles  = 0;
    stalled = 1'b0;
    while (cmd_full && !stalled) begin
      if (cycles == TIMEOUT) begin
        stalled = 1'b1;
      end else begin
        @(posedge clk);
        #1;
        cycles++;
      end
    end
  endtask

  task automatic wait_rsp();
    int cycles;
    cycles = 0;
    while (rsp_empty) begin
      if (cycles == TIMEOUT) begin
        report_fail("timeout waiting for a response");
      end else begin
        @(posedge clk);
        #1;
        cycles++;
      end
    end
  endtask

  // Compare the head against vector k, then pop it
  task automatic check_response(input int k);
    wait_rsp();
    assert (rsp.rdata === v_rdata[k]) else begin
      report_fail($sformatf("MISMATCH rsp.rdata got %h expected %h (vector %0d)",
                            rsp.rdata, v_rdata[k], k));
    end
    assert (rsp.err === v_err[k]) else begin
      report_fail($sformatf("MISMATCH rsp.err got %h expected %h (vector %0d)",
                            rsp.err, v_err[k], k));
    end
    rsp_pop = 1'b1;
    @(posedge clk);
    #1;
    rsp_pop = 1'b0;
    checked++;
  endtask

  // Two LFSR bits give 0 to 3 idle cycles
  task automatic random_gap();
    int gap;
    gap = 0;
    for (int b = 0; b < 2; b++) begin
      lfsr = lfsr_step(lfsr);
      gap  = (gap << 1) | lfsr[0];
    end
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin : main
    int   accepted;
    int   next_push;
    logic stalled;
    rst_n    = 1'b0;
    cmd_push = 1'b0;
    cmd      = '0;
    rsp_pop  = 1'b0;
    lfsr     = 16'd899;
    checked  = 0;
    $readmemh(VEC_FILE, raw);
    load_vectors();
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset state, and silence without commands
    assert (cmd_full === 1'b0) else begin
      report_fail($sformatf("MISMATCH cmd_full got %h expected %h", cmd_full, 1'b0));
    end
    repeat (20) @(posedge clk);
    #1;
    assert (rsp_empty === 1'b1) else begin
      report_fail($sformatf("MISMATCH rsp_empty got %h expected %h", rsp_empty, 1'b1));
    end

    // One command at a time up to the stall marker
    for (int k = 0; k < stall_start; k++) begin
      push_vector(k);
      check_response(k);
    end

    // Popping held off, pushes go on until the master stops taking commands
    next_push = stall_start;
    accepted  = 0;
    stalled   = 1'b0;
    while (!stalled && next_push < num_vec && v_phase[next_push] == 1) begin
      wait_room_or_stall(stalled);
      if (!stalled) begin
        push_vector(next_push);
        next_push++;
        accepted++;
      end
    end
    assert (stalled) else begin
      report_fail("command buffer never stayed full while responses were held back");
    end
    assert (accepted <= CMD_DEPTH + RSP_DEPTH + 1) else begin
      report_fail($sformatf("command buffer accepted %0d commands before filling", accepted));
    end

    // Drain with random gaps while the rest is pushed
    fork
      begin
        for (int k = next_push; k < num_vec; k++) begin
          wait_not_full();
          push_vector(k);
        end
      end
      begin
        for (int k = stall_start; k < num_vec; k++) begin
          check_response(k);
          random_gap();
        end
      end
    join

    if (checked == num_vec && rsp_empty) begin
      $display("all tests passed");
      $finish;
    end else begin
      report_fail($sformatf("checked %0d of %0d responses, or extra responses remain",
                            checked, num_vec));
    end
  end

endmodule

/* tb/ahb_subsys_testdata.txt */
// Columns: op addr wdata expected_rdata expected_err
// op 0 read, 1 write, 2 phase marker (addr column = phase, 1 stall, 2 random gaps), 3 end
1 00000000 11111111 00000000 0
1 00000004 22222222 00000000 0
1 000003FC DEADBEEF 00000000 0
0 00000000 00000000 11111111 0
0 00000004 00000000 22222222 0
0 000003FC 00000000 DEADBEEF 0
0 00000008 00000000 00000000 0
1 40000000 A5A50001 00000000 0
1 40000004 A5A50002 00000000 0
1 40000008 A5A50003 00000000 0
1 4000000C FFFFFFFF 00000000 0
0 40000000 00000000 A5A50001 0
0 40000004 00000000 A5A50002 0
0 40000008 00000000 A5A50003 0
0 4000000C 00000000 5EA50202 0
0 00000400 00000000 00000000 1
1 20000000 12345678 00000000 1
0 40000010 00000000 00000000 1
0 00000004 00000000 22222222 0
2 00000001 00000000 00000000 0
1 00000010 00C0FFEE 00000000 0
0 4000000C 00000000 5EA50202 0
0 80000000 00000000 00000000 1
1 40000004 CAFE0001 00000000 0
0 00000010 00000000 00C0FFEE 0
0 40000004 00000000 CAFE0001 0
1 00000014 0BADF00D 00000000 0
0 00000014 00000000 0BADF00D 0
1 00001000 55555555 00000000 1
0 00000000 00000000 11111111 0
2 00000002 00000000 00000000 0
0 40000008 00000000 A5A50003 0
1 00000018 76543210 00000000 0
0 40000020 00000000 00000000 1
0 00000018 00000000 76543210 0
0 40000000 00000000 A5A50001 0
3 00000000 00000000 00000000 0

/* verilog.f */
src/ahb_pkg.sv
src/sync_fifo.sv
src/ahb_cmd_master.sv
src/ahb_lite_bus.sv
src/ahb_sram_slave.sv
src/ahb_periph_slave.sv
src/ahb_subsys_top.sv
tb/ahb_subsys_props.sv
tb/tb_ahb_subsys.sv

/* Bender.yml */
package:
  name: ahb_subsys

sources:
  - src/ahb_pkg.sv
  - src/sync_fifo.sv
  - src/ahb_cmd_master.sv
  - src/ahb_lite_bus.sv
  - src/ahb_sram_slave.sv
  - src/ahb_periph_slave.sv
  - src/ahb_subsys_top.sv
  - target: test
    files:
      - tb/ahb_subsys_props.sv
      - tb/tb_ahb_subsys.sv
